//--- project.f
riscv_pkg.sv
riscv_operand_if.sv
riscv_operand_sel.sv
riscv_icu.sv
riscv_lsu.sv
riscv_misalign.sv
riscv_estage.sv
tb_clkgen.sv
riscv_estage_chk.sv
tb_riscv_estage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_riscv_estage -f project.f
out=$(./obj_dir/Vtb_riscv_estage) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "^sim passed$"

//--- tb_riscv_estage.sv
`timescale 1ns/1ns

module tb_riscv_estage import riscv_pkg::*; ();

  logic            i_riscv_estage_clk;
  logic            i_arst_n;
  logic [XLEN-1:0] i_imm_m, i_rs1data, i_rs2data, i_rdata_wb, i_rddata_m;
  logic [XLEN-1:0] i_pc, i_simm, i_immextended;
  fwd_sel_e        i_fwda, i_fwdb;
  logic            i_oprnd1sel, i_oprnd2sel, i_imm_reg;
  alu_op_e         i_aluctrl;
  logic [3:0]      i_mulctrl, i_divctrl, i_bcond;
  func_sel_e       i_funcsel;
  logic [2:0]      i_memext;
  logic [6:0]      i_opcode;
  mem_size_e       i_storesrc;
  logic [1:0]      i_lr, i_sc;
  logic            i_amo, i_memw, i_memr, i_gtrap, i_rtrap;
  logic [XLEN-1:0] o_result, o_store_data, o_csrwritedata, o_dcache_addr, o_rddata_sc;
  logic            o_branchtaken, o_div_en, o_mul_en, o_icu_valid;
  logic            o_inst_addr_misaligned, o_store_addr_misaligned, o_load_addr_misaligned;
  logic            o_dcache_wren, o_dcache_rden;
  logic [31:0]     lfsr_state;

  tb_clkgen u_clkgen (
    .o_clk    (i_riscv_estage_clk),
    .o_arst_n (i_arst_n)
  );

  riscv_estage u_dut (.*);

  bind riscv_estage riscv_estage_chk u_chk (
    .i_clk       (i_riscv_estage_clk),
    .i_arst_n    (i_arst_n),
    .i_gtrap     (i_gtrap),
    .i_mul_en    (o_mul_en),
    .i_icu_valid (o_icu_valid),
    .i_wren      (o_dcache_wren),
    .i_rden      (o_dcache_rden)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Taps 32, 22, 2, 1
  endfunction

  task automatic rand_word(output logic [XLEN-1:0] v, input int nbits);
    int k;
    v = '0;
    for (k = 0; k < nbits; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[XLEN-2:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic wait_drive_slot();
    @(posedge i_riscv_estage_clk);
    #1;
  endtask

  function automatic logic [XLEN-1:0] pick_fwd(input fwd_sel_e sel,
                                               input logic [XLEN-1:0] reg_val);
    case (sel)
      FWD_WB:    return i_rdata_wb;
      FWD_MEM:   return i_rddata_m;
      FWD_IMM_M: return i_imm_m;
      default:   return reg_val;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    logic [XLEN-1:0] sum;
    logic [5:0]      sh;
    sum = a + b;
    sh  = b[5:0];
    case (op)
      ALU_ADD:  return sum;
      ALU_SUB:  return a + ~b + 64'd1;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return (a[XLEN-1] != b[XLEN-1]) ? XLEN'(a[XLEN-1]) : XLEN'(a < b);
      ALU_SLTU: return XLEN'(a < b);
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_LUI:  return b;
      ALU_JALR: return {sum[XLEN-1:1], 1'b0};
      default:  return '0;
    endcase
  endfunction

  task automatic init_inputs();
    i_imm_m       = '0;
    i_rs1data     = '0;
    i_rs2data     = '0;
    i_rdata_wb    = '0;
    i_rddata_m    = '0;
    i_pc          = '0;
    i_simm        = '0;
    i_immextended = '0;
    i_fwda        = FWD_REG;
    i_fwdb        = FWD_REG;
    i_oprnd1sel   = 1'b0;
    i_oprnd2sel   = 1'b0;
    i_imm_reg     = 1'b0;
    i_aluctrl     = ALU_ADD;
    i_funcsel     = FUNC_ALU;
    i_mulctrl     = '0;
    i_divctrl     = '0;
    i_bcond       = '0;
    i_memext      = '0;
    i_opcode      = '0;
    i_storesrc    = MEM_BYTE;
    i_lr          = '0;
    i_sc          = '0;
    i_amo         = 1'b0;
    i_memw        = 1'b0;
    i_memr        = 1'b0;
    i_gtrap       = 1'b0;
    i_rtrap       = 1'b0;
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (i_arst_n !== 1'b1) begin
      if (cycles > 20) begin
        abort_run("Reset was never released");
      end
      @(posedge i_riscv_estage_clk);
      cycles++;
    end
  endtask

  task automatic test_fwd_alu();
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] dctl;
    logic [XLEN-1:0] fa;
    logic [XLEN-1:0] fb;
    alu_op_e         op;
    int              rep;
    int              s;
    for (rep = 0; rep < 3; rep++) begin
      for (s = 0; s < 4; s++) begin
        wait_drive_slot();
        rand_word(i_rs1data, XLEN);
        rand_word(i_rs2data, XLEN);
        rand_word(i_rdata_wb, XLEN);
        rand_word(i_rddata_m, XLEN);
        rand_word(i_imm_m, XLEN);
        rand_word(i_pc, XLEN);
        rand_word(i_simm, XLEN);
        rand_word(r, 6);
        rand_word(dctl, 4);
        op = alu_op_e'(6'(r[5:2] % 12));
        i_aluctrl   = op;
        i_oprnd1sel = r[0];
        i_oprnd2sel = r[1];
        i_fwda      = fwd_sel_e'(2'(s));
        i_fwdb      = fwd_sel_e'(2'(3 - s));          // Other select on rs2
        i_funcsel   = FUNC_ALU;
        i_divctrl   = dctl[3:0];
        #1;
        fa = pick_fwd(i_fwda, i_rs1data);
        fb = pick_fwd(i_fwdb, i_rs2data);
        check_word($sformatf("fwd_alu op %0d sel %0d", op, s),
                   alu_model(op, i_oprnd1sel ? fa : i_pc, i_oprnd2sel ? i_simm : fb), o_result);
        check_word("fwd_store_data", fb, o_store_data);
        check_bit("fwd_alu_valid", 1'b1, o_icu_valid);
        check_bit("div_en", dctl[3], o_div_en);       // Divide stall is the top control bit
        check_bit("mul_en_idle", 1'b0, o_mul_en);
      end
    end
  endtask

  task automatic test_branch();
    logic exp;
    int   k;
    int   en;
    int   eq;
    for (k = 0; k < 8; k++) begin
      if (k == 2 || k == 3) continue;               // Reserved funct3
      for (en = 0; en < 2; en++) begin
        for (eq = 0; eq < 2; eq++) begin
          wait_drive_slot();
          rand_word(i_rs1data, XLEN);
          rand_word(i_rs2data, XLEN);
          if (eq == 1) i_rs2data = i_rs1data;
          i_fwda  = FWD_REG;
          i_fwdb  = FWD_REG;
          i_bcond = {1'(en), 3'(k)};
          #1;
          case (k)
            0:       exp = i_rs1data == i_rs2data;
            1:       exp = i_rs1data != i_rs2data;
            4:       exp = $signed(i_rs1data) < $signed(i_rs2data);
            5:       exp = $signed(i_rs1data) >= $signed(i_rs2data);
            6:       exp = i_rs1data < i_rs2data;
            default: exp = i_rs1data >= i_rs2data;
          endcase
          check_bit($sformatf("branch f3 %0d en %0d", k, en), exp & 1'(en), o_branchtaken);
        end
      end
    end
    i_bcond = '0;
  endtask

  task automatic test_mul(input logic hi);
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [2*XLEN-1:0] prod;
    int                edges;
    rand_word(a, XLEN);
    rand_word(b, XLEN);
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    wait_drive_slot();
    i_rs1data = a;
    i_rs2data = b;
    i_fwda    = FWD_REG;
    i_fwdb    = FWD_REG;
    i_funcsel = FUNC_MUL;
    i_mulctrl = {1'b1, 2'b00, hi};
    edges = 0;
    #1;
    check_bit("mul_en", 1'b1, o_mul_en);
    while (!o_icu_valid) begin
      if (edges > MUL_CYCLES + 4) begin
        abort_run("Multiply never raised o_icu_valid");
      end
      @(posedge i_riscv_estage_clk);
      #2;
      edges++;
    end
    // The first edge counted is the start edge
    check_word("mul_latency", XLEN'(MUL_CYCLES + 1), XLEN'(edges));
    check_word(hi ? "mul_high" : "mul_low", hi ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0],
               o_result);
    wait_drive_slot();
    check_bit("mul_valid_pulse", 1'b0, o_icu_valid);   // Valid lasts one cycle
    i_mulctrl = '0;                                 // Drop before a second start
    i_funcsel = FUNC_ALU;
    #1;
    check_bit("mul_en_low", 1'b0, o_mul_en);
  endtask

  task automatic test_misalign();
    logic [XLEN-1:0] base;
    logic            exp;
    int              off;
    int              sz;
    int              st;
    i_fwda      = FWD_REG;
    i_oprnd1sel = 1'b1;
    i_oprnd2sel = 1'b1;
    i_aluctrl   = ALU_ADD;
    i_funcsel   = FUNC_ALU;
    for (off = 0; off < 8; off++) begin
      for (sz = 0; sz < 4; sz++) begin
        for (st = 0; st < 2; st++) begin
          wait_drive_slot();
          rand_word(base, XLEN);
          i_rs1data  = {base[XLEN-1:3], 3'b000};
          i_simm     = XLEN'(off);
          i_opcode   = (st == 1) ? OPC_STORE : OPC_LOAD;
          i_memext   = {1'b0, 2'(sz)};
          i_storesrc = mem_size_e'(2'(sz));
          i_memw     = 1'(st);
          i_memr     = 1'(1 - st);
          #1;
          exp = (off % (1 << sz)) != 0;
          check_bit($sformatf("mis off %0d size %0d store %0d", off, sz, st), exp,
                    (st == 1) ? o_store_addr_misaligned : o_load_addr_misaligned);
          check_bit("mis_other_flag", 1'b0,
                    (st == 1) ? o_load_addr_misaligned : o_store_addr_misaligned);
          check_bit("mis_strobe", !exp, (st == 1) ? o_dcache_wren : o_dcache_rden);
          check_bit("mis_inst_quiet", 1'b0, o_inst_addr_misaligned);
        end
      end
    end
    i_memw = 1'b0;
    i_memr = 1'b0;
    for (off = 0; off < 8; off++) begin
      wait_drive_slot();
      i_simm   = XLEN'(off);
      i_opcode = (off < 4) ? OPC_JAL : OPC_JALR;
      #1;
      check_bit($sformatf("inst_mis off %0d", off), (off % 4) != 0, o_inst_addr_misaligned);
    end
    i_opcode = '0;
  endtask

  task automatic drive_atomic(input logic [1:0] lr, input logic [1:0] sc, input logic memw,
                              input logic memr, input logic gtrap,
                              input logic [XLEN-1:0] addr);
    wait_drive_slot();
    i_rs1data = addr;
    i_lr      = lr;
    i_sc      = sc;
    i_memw    = memw;
    i_memr    = memr;
    i_gtrap   = gtrap;
    #1;
  endtask

  task automatic test_lr_sc();
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] addr;
    rand_word(base, XLEN);
    addr        = {base[XLEN-1:3], 3'b000};       // Doubleword aligned
    i_opcode    = OPC_AMO;
    i_storesrc  = MEM_DOUBLE;
    i_memext    = 3'b011;
    i_simm      = XLEN'(8);                         // ALU result differs from rs1
    i_fwda      = FWD_REG;
    i_oprnd1sel = 1'b1;
    i_oprnd2sel = 1'b1;
    i_aluctrl   = ALU_ADD;
    i_funcsel   = FUNC_ALU;
    drive_atomic(2'b11, 2'b00, 1'b0, 1'b1, 1'b0, addr);
    check_bit("lr_rden", 1'b1, o_dcache_rden);
    check_word("lr_addr", addr, o_dcache_addr);
    drive_atomic(2'b00, 2'b11, 1'b1, 1'b0, 1'b0, addr);
    check_bit("sc_wren", 1'b1, o_dcache_wren);
    check_word("sc_rddata", XLEN'(0), o_rddata_sc);
    drive_atomic(2'b00, 2'b11, 1'b1, 1'b0, 1'b0, addr);
    check_bit("sc_again_wren", 1'b0, o_dcache_wren);
    check_word("sc_again_rddata", XLEN'(1), o_rddata_sc);
    drive_atomic(2'b11, 2'b00, 1'b0, 1'b1, 1'b0, addr);
    drive_atomic(2'b00, 2'b11, 1'b1, 1'b0, 1'b0, addr + XLEN'(8));
    check_bit("sc_other_wren", 1'b0, o_dcache_wren);
    check_word("sc_other_rddata", XLEN'(1), o_rddata_sc);
    drive_atomic(2'b11, 2'b00, 1'b0, 1'b1, 1'b0, addr);
    drive_atomic(2'b00, 2'b00, 1'b1, 1'b0, 1'b1, addr);
    check_bit("gtrap_wren", 1'b0, o_dcache_wren);
    check_word("plain_addr", addr + XLEN'(8), o_dcache_addr);
    drive_atomic(2'b00, 2'b00, 1'b0, 1'b1, 1'b1, addr);
    check_bit("gtrap_rden", 1'b0, o_dcache_rden);
    drive_atomic(2'b00, 2'b11, 1'b1, 1'b0, 1'b0, addr);   // Trap dropped the reservation
    check_bit("sc_after_trap_wren", 1'b0, o_dcache_wren);
    check_word("sc_after_trap_rddata", XLEN'(1), o_rddata_sc);
    drive_atomic(2'b00, 2'b00, 1'b0, 1'b0, 1'b0, addr);
    i_opcode = '0;
  endtask

  task automatic test_csr();
    int sel;
    for (sel = 0; sel < 2; sel++) begin
      wait_drive_slot();
      rand_word(i_immextended, XLEN);
      rand_word(i_rdata_wb, XLEN);
      i_fwda    = FWD_WB;                           // rs1 arrives by forwarding
      i_imm_reg = 1'(sel);
      i_funcsel = FUNC_CSR_PASS;
      #1;
      check_word("csr_wdata", (sel == 1) ? i_immextended : i_rdata_wb, o_csrwritedata);
      check_word("csr_pass_result", i_rdata_wb, o_result);
      check_bit("csr_pass_valid", 1'b1, o_icu_valid);
    end
  endtask

  initial begin
    lfsr_state = 32'h3bff;
    init_inputs();
    wait_reset();
    test_fwd_alu();
    test_branch();
    test_mul(1'b0);
    test_mul(1'b1);
    test_misalign();
    test_lr_sc();
    test_csr();
    $display("sim passed");
    $finish;
  end

endmodule

//--- riscv_estage_chk.sv
`timescale 1ns/1ns

module riscv_estage_chk import riscv_pkg::*; (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_gtrap,
  input logic i_mul_en,
  input logic i_icu_valid,
  input logic i_wren,
  input logic i_rden
);

  logic [7:0] mul_wait;                             // Edges with a multiply still pending

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mul_wait <= '0;
    end else if (i_mul_en && !i_icu_valid) begin
      mul_wait <= mul_wait + 8'd1;
    end else begin
      mul_wait <= '0;
    end
  end

  a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_wren && i_rden)) else $error("cache read and write strobes high together");

  a_trap_mask: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_gtrap |-> (!i_wren && !i_rden)) else $error("cache strobe high during trap entry");

  a_mul_done: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    mul_wait <= 8'(MUL_CYCLES + 2)) else $error("multiply never signalled valid");

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;                      // 4 ns period
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (8) @(posedge o_clk);
    #1 o_arst_n = 1'b1;                             // Release away from the edge
  end

endmodule

//--- riscv_estage.sv
`timescale 1ns/1ns

module riscv_estage import riscv_pkg::*; (
  input  logic            i_riscv_estage_clk,
  input  logic            i_arst_n,
  input  logic [XLEN-1:0] i_imm_m,
  input  logic [XLEN-1:0] i_rs1data,
  input  logic [XLEN-1:0] i_rs2data,
  input  fwd_sel_e        i_fwda,
  input  fwd_sel_e        i_fwdb,
  input  logic [XLEN-1:0] i_rdata_wb,
  input  logic [XLEN-1:0] i_rddata_m,
  input  logic            i_oprnd1sel,
  input  logic            i_oprnd2sel,
  input  logic [XLEN-1:0] i_pc,
  input  alu_op_e         i_aluctrl,
  input  logic [3:0]      i_mulctrl,
  input  logic [3:0]      i_divctrl,
  input  func_sel_e       i_funcsel,
  input  logic [XLEN-1:0] i_simm,
  input  logic [3:0]      i_bcond,
  input  logic            i_imm_reg,
  input  logic [XLEN-1:0] i_immextended,
  input  logic [2:0]      i_memext,                 // Load funct3, [1:0] is the size
  input  logic [6:0]      i_opcode,
  input  mem_size_e       i_storesrc,
  input  logic [1:0]      i_lr,
  input  logic [1:0]      i_sc,
  input  logic            i_amo,
  input  logic            i_memw,
  input  logic            i_memr,
  input  logic            i_gtrap,
  input  logic            i_rtrap,
  output logic [XLEN-1:0] o_result,
  output logic [XLEN-1:0] o_store_data,
  output logic            o_branchtaken,
  output logic            o_div_en,
  output logic            o_mul_en,
  output logic            o_icu_valid,
  output logic [XLEN-1:0] o_csrwritedata,
  output logic            o_inst_addr_misaligned,
  output logic            o_store_addr_misaligned,
  output logic            o_load_addr_misaligned,
  output logic            o_dcache_wren,
  output logic            o_dcache_rden,
  output logic [XLEN-1:0] o_dcache_addr,
  output logic [XLEN-1:0] o_rddata_sc
);

  riscv_operand_if u_ops_if ();

  assign o_mul_en     = i_mulctrl[3];               // Stall request to the hazard unit
  assign o_div_en     = i_divctrl[3];
  assign o_store_data = u_ops_if.fwd_b;

  riscv_operand_sel u_operand_sel (
    .i_rs1data      (i_rs1data),
    .i_rs2data      (i_rs2data),
    .i_rdata_wb     (i_rdata_wb),
    .i_rddata_m     (i_rddata_m),
    .i_imm_m        (i_imm_m),
    .i_pc           (i_pc),
    .i_simm         (i_simm),
    .i_immextended  (i_immextended),
    .i_fwda         (i_fwda),
    .i_fwdb         (i_fwdb),
    .i_oprnd1sel    (i_oprnd1sel),
    .i_oprnd2sel    (i_oprnd2sel),
    .i_imm_reg      (i_imm_reg),
    .o_csrwritedata (o_csrwritedata),
    .ops            (u_ops_if)
  );

  riscv_icu u_icu (
    .i_riscv_icu_clk (i_riscv_estage_clk),
    .i_arst_n        (i_arst_n),
    .ops             (u_ops_if),
    .i_aluctrl       (i_aluctrl),
    .i_bcond         (i_bcond),
    .i_mulctrl       (i_mulctrl),
    .i_funcsel       (i_funcsel),
    .o_branch_taken  (o_branchtaken),
    .o_valid         (o_icu_valid),
    .o_result        (o_result)
  );

  riscv_lsu u_lsu (
    .i_riscv_lsu_clk (i_riscv_estage_clk),
    .i_arst_n        (i_arst_n),
    .ops             (u_ops_if),
    .i_alu_result    (o_result),
    .i_lr            (i_lr),
    .i_sc            (i_sc),
    .i_amo           (i_amo),
    .i_memw          (i_memw),
    .i_memr          (i_memr),
    .i_gtrap         (i_gtrap),
    .i_rtrap         (i_rtrap),
    .i_misaligned    (o_load_addr_misaligned | o_store_addr_misaligned),
    .o_wren          (o_dcache_wren),
    .o_rden          (o_dcache_rden),
    .o_addr          (o_dcache_addr),
    .o_sc_rdvalue    (o_rddata_sc)
  );

  riscv_misalign u_misalign (
    .i_opcode       (i_opcode),
    .i_result       (o_result),
    .i_branch_taken (o_branchtaken),
    .i_load_sel     (mem_size_e'(i_memext[1:0])),
    .i_store_sel    (i_storesrc),
    .o_inst_mis     (o_inst_addr_misaligned),
    .o_load_mis     (o_load_addr_misaligned),
    .o_store_mis    (o_store_addr_misaligned)
  );

endmodule

//--- riscv_misalign.sv
`timescale 1ns/1ns

module riscv_misalign import riscv_pkg::*; (
  input  logic [6:0]      i_opcode,
  input  logic [XLEN-1:0] i_result,                 // Target or data address
  input  logic            i_branch_taken,
  input  mem_size_e       i_load_sel,
  input  mem_size_e       i_store_sel,
  output logic            o_inst_mis,
  output logic            o_load_mis,
  output logic            o_store_mis
);

  logic is_jump;
  logic is_store;

  function automatic logic size_mis(input logic [2:0] addr_lo, input mem_size_e size);
    case (size)
      MEM_HALF:   return addr_lo[0];
      MEM_WORD:   return |addr_lo[1:0];
      MEM_DOUBLE: return |addr_lo;
      default:    return 1'b0;                      // Bytes are always aligned
    endcase
  endfunction

  assign is_jump = ((i_opcode == OPC_BRANCH) && i_branch_taken) ||
                   (i_opcode == OPC_JAL) || (i_opcode == OPC_JALR);

  // AMO address reaches the ALU as rs1 plus zero
  assign is_store = (i_opcode == OPC_STORE) || (i_opcode == OPC_AMO);

  // No compressed support, so targets need 4-byte alignment
  assign o_inst_mis  = is_jump & (|i_result[1:0]);
  assign o_load_mis  = (i_opcode == OPC_LOAD) & size_mis(i_result[2:0], i_load_sel);
  assign o_store_mis = is_store & size_mis(i_result[2:0], i_store_sel);

endmodule

//--- riscv_lsu.sv
`timescale 1ns/1ns

module riscv_lsu import riscv_pkg::*; (
  input  logic            i_riscv_lsu_clk,
  input  logic            i_arst_n,
  riscv_operand_if.sink   ops,
  input  logic [XLEN-1:0] i_alu_result,
  input  logic [1:0]      i_lr,                     // [0] LR, [1] doubleword
  input  logic [1:0]      i_sc,                     // [0] SC, [1] doubleword
  input  logic            i_amo,
  input  logic            i_memw,
  input  logic            i_memr,
  input  logic            i_gtrap,
  input  logic            i_rtrap,
  input  logic            i_misaligned,
  output logic            o_wren,
  output logic            o_rden,
  output logic [XLEN-1:0] o_addr,
  output logic [XLEN-1:0] o_sc_rdvalue
);

  logic            req_ok;
  logic            sc_ok;
  logic            res_valid;
  logic [XLEN-1:0] res_addr;
  logic            res_dw;

  // Atomics address straight from rs1
  assign o_addr = (i_lr[0] | i_sc[0] | i_amo) ? ops.fwd_a : i_alu_result;
  assign req_ok = ~(i_gtrap | i_rtrap | i_misaligned);

  assign sc_ok = i_sc[0] & req_ok & res_valid &
                 (res_addr == o_addr) & (res_dw == i_sc[1]);

  // AMOs go to the cache as a read, the cache does the write back
  assign o_wren       = i_sc[0] ? sc_ok : (req_ok & i_memw & ~i_amo);
  assign o_rden       = req_ok & i_memr;
  assign o_sc_rdvalue = {{(XLEN-1){1'b0}}, ~sc_ok};   // 0 means success

  always_ff @(posedge i_riscv_lsu_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      res_valid <= 1'b0;
    end else if (i_sc[0] | i_gtrap | i_rtrap) begin
      res_valid <= 1'b0;                            // SC consumes the reservation
    end else if (i_lr[0] & req_ok) begin
      res_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_riscv_lsu_clk) begin
    if (i_lr[0] & req_ok) begin
      res_addr <= o_addr;
      res_dw   <= i_lr[1];
    end
  end

endmodule

//--- riscv_icu.sv
`timescale 1ns/1ns

module riscv_icu import riscv_pkg::*; (
  input  logic            i_riscv_icu_clk,
  input  logic            i_arst_n,
  riscv_operand_if.sink   ops,
  input  alu_op_e         i_aluctrl,
  input  logic [3:0]      i_bcond,
  input  logic [3:0]      i_mulctrl,                // [3] start, [0] high half
  input  func_sel_e       i_funcsel,
  output logic            o_branch_taken,
  output logic            o_valid,
  output logic [XLEN-1:0] o_result
);

  logic [XLEN-1:0]      alu_res;
  logic [5:0]           shamt;
  logic                 cmp_eq;
  logic                 cmp_lt;
  logic                 cmp_ltu;
  logic                 br_cond;
  logic                 mul_start;
  logic                 mul_busy;
  logic                 mul_done;
  logic [MUL_CNT_W-1:0] mul_cnt;
  logic [2*XLEN-1:0]    mul_prod;
  logic [XLEN:0]        mul_sum;
  logic [XLEN-1:0]      mul_half;

  assign shamt = ops.alu_b[5:0];

  always_comb begin
    case (i_aluctrl)
      ALU_ADD:  alu_res = ops.alu_a + ops.alu_b;
      ALU_SUB:  alu_res = ops.alu_a - ops.alu_b;
      ALU_SLL:  alu_res = ops.alu_a << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(ops.alu_a) < $signed(ops.alu_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, ops.alu_a < ops.alu_b};
      ALU_XOR:  alu_res = ops.alu_a ^ ops.alu_b;
      ALU_SRL:  alu_res = ops.alu_a >> shamt;
      ALU_SRA:  alu_res = $signed(ops.alu_a) >>> shamt;
      ALU_OR:   alu_res = ops.alu_a | ops.alu_b;
      ALU_AND:  alu_res = ops.alu_a & ops.alu_b;
      ALU_LUI:  alu_res = ops.alu_b;
      ALU_JALR: alu_res = (ops.alu_a + ops.alu_b) & ~XLEN'(1);
      default:  alu_res = '0;
    endcase
  end

  // Branches compare the forwarded registers, not the ALU operands
  assign cmp_eq  = ops.fwd_a == ops.fwd_b;
  assign cmp_lt  = $signed(ops.fwd_a) < $signed(ops.fwd_b);
  assign cmp_ltu = ops.fwd_a < ops.fwd_b;

  always_comb begin
    case (i_bcond[2:0])
      BR_BEQ:  br_cond = cmp_eq;
      BR_BNE:  br_cond = ~cmp_eq;
      BR_BLT:  br_cond = cmp_lt;
      BR_BGE:  br_cond = ~cmp_lt;
      BR_BLTU: br_cond = cmp_ltu;
      BR_BGEU: br_cond = ~cmp_ltu;
      default: br_cond = 1'b0;                      // Reserved funct3
    endcase
  end

  assign o_branch_taken = i_bcond[BR_EN_BIT] & br_cond;

  // Shift-add multiplier; caller holds fwd_a steady while busy
  assign mul_start = i_mulctrl[3] & ~mul_busy & ~mul_done;
  assign mul_sum   = {1'b0, mul_prod[2*XLEN-1:XLEN]} +
                     (mul_prod[0] ? {1'b0, ops.fwd_a} : '0);

  always_ff @(posedge i_riscv_icu_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mul_busy <= 1'b0;
      mul_done <= 1'b0;
      mul_cnt  <= '0;
    end else if (mul_busy) begin
      mul_cnt <= mul_cnt + 1'b1;
      if (mul_cnt == MUL_CNT_W'(MUL_CYCLES-1)) begin   // Last partial product added
        mul_busy <= 1'b0;
        mul_done <= 1'b1;
      end
    end else if (mul_done) begin
      mul_done <= 1'b0;                             // One-cycle valid pulse
    end else if (mul_start) begin
      mul_busy <= 1'b1;
      mul_cnt  <= '0;
    end
  end

  always_ff @(posedge i_riscv_icu_clk) begin
    if (mul_start) begin
      mul_prod <= {{XLEN{1'b0}}, ops.fwd_b};        // Multiplier in the low half
    end else if (mul_busy) begin
      mul_prod <= {mul_sum, mul_prod[XLEN-1:1]};
    end
  end

  assign mul_half = i_mulctrl[0] ? mul_prod[2*XLEN-1:XLEN] : mul_prod[XLEN-1:0];

  always_comb begin
    case (i_funcsel)
      FUNC_ALU: begin
        o_result = alu_res;
        o_valid  = 1'b1;
      end
      FUNC_MUL: begin
        o_result = mul_half;
        o_valid  = mul_done;
      end
      FUNC_CSR_PASS: begin
        o_result = ops.fwd_a;                       // Old value path for CSR ops
        o_valid  = 1'b1;
      end
      default: begin
        o_result = alu_res;
        o_valid  = 1'b0;
      end
    endcase
  end

endmodule

//--- riscv_operand_sel.sv
`timescale 1ns/1ns

module riscv_operand_sel import riscv_pkg::*; (
  input  logic [XLEN-1:0] i_rs1data,
  input  logic [XLEN-1:0] i_rs2data,
  input  logic [XLEN-1:0] i_rdata_wb,
  input  logic [XLEN-1:0] i_rddata_m,
  input  logic [XLEN-1:0] i_imm_m,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_simm,
  input  logic [XLEN-1:0] i_immextended,
  input  fwd_sel_e        i_fwda,
  input  fwd_sel_e        i_fwdb,
  input  logic            i_oprnd1sel,
  input  logic            i_oprnd2sel,
  input  logic            i_imm_reg,
  output logic [XLEN-1:0] o_csrwritedata,
  riscv_operand_if.source ops
);

  // Same forwarding network serves both source registers
  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                              input logic [XLEN-1:0] rs);
    case (sel)
      FWD_WB:    return i_rdata_wb;
      FWD_MEM:   return i_rddata_m;
      FWD_IMM_M: return i_imm_m;
      default:   return rs;                         // No hazard, register file value
    endcase
  endfunction

  always_comb begin
    ops.fwd_a = fwd_mux(i_fwda, i_rs1data);
    ops.fwd_b = fwd_mux(i_fwdb, i_rs2data);
  end

  assign ops.alu_a = i_oprnd1sel ? ops.fwd_a : i_pc;     // PC for AUIPC, JAL, branches
  assign ops.alu_b = i_oprnd2sel ? i_simm : ops.fwd_b;

  // CSRxxI forms use the zero-extended uimm field
  assign o_csrwritedata = i_imm_reg ? i_immextended : ops.fwd_a;

endmodule

//--- riscv_operand_if.sv
`timescale 1ns/1ns

interface riscv_operand_if import riscv_pkg::*; ();

  logic [XLEN-1:0] fwd_a;                           // Forwarded rs1
  logic [XLEN-1:0] fwd_b;                           // Forwarded rs2, also store data
  logic [XLEN-1:0] alu_a;                           // PC or forwarded rs1
  logic [XLEN-1:0] alu_b;                           // Forwarded rs2 or immediate

  modport source (
    output fwd_a,
    output fwd_b,
    output alu_a,
    output alu_b
  );

  modport sink (
    input fwd_a,
    input fwd_b,
    input alu_a,
    input alu_b
  );

endinterface

//--- riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN       = 64;
  localparam int MUL_CYCLES = 64;                   // Shift-add iterations
  localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_AMO    = 7'b0101111;   // LR, SC and AMOs

  // Branch condition is {enable, funct3}
  localparam int BR_EN_BIT = 3;

  localparam logic [2:0] BR_BEQ  = 3'b000;
  localparam logic [2:0] BR_BNE  = 3'b001;
  localparam logic [2:0] BR_BLT  = 3'b100;
  localparam logic [2:0] BR_BGE  = 3'b101;
  localparam logic [2:0] BR_BLTU = 3'b110;
  localparam logic [2:0] BR_BGEU = 3'b111;

  typedef enum logic [5:0] {
    ALU_ADD  = 6'd0,
    ALU_SUB  = 6'd1,
    ALU_SLL  = 6'd2,
    ALU_SLT  = 6'd3,
    ALU_SLTU = 6'd4,
    ALU_XOR  = 6'd5,
    ALU_SRL  = 6'd6,
    ALU_SRA  = 6'd7,
    ALU_OR   = 6'd8,
    ALU_AND  = 6'd9,
    ALU_LUI  = 6'd10,                               // Operand B passes through
    ALU_JALR = 6'd11                                // Add, then clear bit 0
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG   = 2'd0,                               // Register file read
    FWD_WB    = 2'd1,                               // Writeback stage data
    FWD_MEM   = 2'd2,                               // Memory stage data
    FWD_IMM_M = 2'd3                                // Memory stage immediate
  } fwd_sel_e;

  typedef enum logic [1:0] {
    FUNC_ALU      = 2'd0,
    FUNC_MUL      = 2'd1,
    FUNC_CSR_PASS = 2'd2
  } func_sel_e;

  typedef enum logic [1:0] {
    MEM_BYTE   = 2'd0,
    MEM_HALF   = 2'd1,
    MEM_WORD   = 2'd2,
    MEM_DOUBLE = 2'd3
  } mem_size_e;

endpackage
